//--- design/riscv_v_defines.svh
// Fixed VLEN of 128 and XLEN of 64
// Byte enable count follows from VLEN and the byte width
`ifndef RISCV_V_DEFINES_SVH
`define RISCV_V_DEFINES_SVH

// Vector and scalar data widths
`define RISCV_V_DATA_WIDTH 128
`define RISCV_DATA_WIDTH   64

// Register file geometry
`define RISCV_V_NUM_REGS   32
`define RISCV_V_ADDR_WIDTH 5

`define BYTE_WIDTH         8
`define RISCV_V_NUM_BYTES  (`RISCV_V_DATA_WIDTH / `BYTE_WIDTH)

`endif

//--- design/riscv_v_pkg.sv
// Shared enums for the vector execution slice
// Opcode set covers only the ops this slice implements
package riscv_v_pkg;

    // Ops for the arithmetic and permutation units
    typedef enum logic [2:0] {
        VADD    = 3'd0,
        VSUB    = 3'd1,
        VAND    = 3'd2,
        VOR     = 3'd3,
        VXOR    = 3'd4,
        VMV_S_X = 3'd5,
        VMV_X_S = 3'd6
    } riscv_v_opcode_e;

    // Element width, log2 of the byte count
    typedef enum logic [1:0] {
        OSIZE_8  = 2'd0,
        OSIZE_16 = 2'd1,
        OSIZE_32 = 2'd2,
        OSIZE_64 = 2'd3
    } riscv_v_osize_e;

    // Sequencer states for both execution units
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        READ_REQ  = 3'd1,
        READ_WAIT = 3'd2,
        WRITE_REQ = 3'd3,
        FINISH    = 3'd4
    } riscv_v_unit_state_e;

endpackage

//--- design/riscv_v_permutation_alu.sv
// Scalar input to integer-to-vector must already be sign-extended
// osize_vector is expected one-hot, otherwise results are ORed together
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_permutation_alu
    import riscv_v_pkg::*;
(
    input  logic                           is_i2v,
    input  logic                           is_v2i,
    input  logic [`RISCV_V_DATA_WIDTH-1:0] srca_data,
    input  logic [`RISCV_V_DATA_WIDTH-1:0] srcb_data,
    input  logic [3:0]                     osize_vector,
    output logic [`RISCV_DATA_WIDTH-1:0]   integer_data_out,
    output logic [`RISCV_V_DATA_WIDTH-1:0] vector_data_out
);

    logic [`RISCV_V_DATA_WIDTH-1:0] v2i_src;
    logic [`RISCV_DATA_WIDTH-1:0]   v2i_result [4];

    // Integer to vector, byte enables mask off the unused bytes later
    assign vector_data_out = srca_data & {`RISCV_V_DATA_WIDTH{is_i2v}};

    assign v2i_src = srcb_data & {`RISCV_V_DATA_WIDTH{is_v2i}};

    // Sign extension of element 0 for 8, 16 and 32 bit widths
    for (genvar w = 0; w < 3; w++) begin : g_v2i
        localparam int OW = `BYTE_WIDTH * (2 ** w);

        assign v2i_result[w] = {{(`RISCV_DATA_WIDTH - OW){v2i_src[OW-1]}}, v2i_src[OW-1:0]}
                             & {`RISCV_DATA_WIDTH{osize_vector[w]}};
    end

    // Full width element needs no extension
    assign v2i_result[3] = v2i_src[`RISCV_DATA_WIDTH-1:0]
                         & {`RISCV_DATA_WIDTH{osize_vector[OSIZE_64]}};

    always_comb begin
        integer_data_out = '0;
        for (int i = 0; i < 4; i++) begin
            integer_data_out |= v2i_result[i];
        end
    end

endmodule

//--- design/riscv_v_arith_unit.sv
// Element-wise vadd/vsub/vand/vor/vxor over a whole vector register
// Always writes all bytes of vd, no masking or tail handling
// A start while busy is ignored
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_arith_unit
    import riscv_v_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  riscv_v_opcode_e                 opcode,
    input  riscv_v_osize_e                  osize,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  vd,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  vs1,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  vs2,
    input  logic                            vrf_gnt,
    input  logic                            vrf_rvalid,
    input  logic [`RISCV_V_DATA_WIDTH-1:0]  vrf_rdata_a,
    input  logic [`RISCV_V_DATA_WIDTH-1:0]  vrf_rdata_b,
    output logic                            vrf_req,
    output logic                            vrf_we,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]  vrf_raddr_a,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]  vrf_raddr_b,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]  vrf_waddr,
    output logic [`RISCV_V_DATA_WIDTH-1:0]  vrf_wdata,
    output logic [`RISCV_V_NUM_BYTES-1:0]   vrf_wbe,
    output logic                            done
);

    riscv_v_unit_state_e            state;
    riscv_v_opcode_e                op_q;
    riscv_v_osize_e                 osize_q;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vd_q;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vs1_q;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vs2_q;
    logic [`RISCV_V_DATA_WIDTH-1:0] src_a_q;
    logic [`RISCV_V_DATA_WIDTH-1:0] src_b_q;
    logic [`RISCV_V_DATA_WIDTH-1:0] src_b_eff;
    logic [`RISCV_V_DATA_WIDTH-1:0] addsub_result;
    logic [3:0]                     elem_mask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (start) state <= READ_REQ;
                READ_REQ:  if (vrf_gnt) state <= READ_WAIT;
                READ_WAIT: if (vrf_rvalid) state <= WRITE_REQ;
                WRITE_REQ: if (vrf_gnt) state <= FINISH;
                default:   state <= IDLE;
            endcase
        end
    end

    // Command and operand capture
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            op_q    <= opcode;
            osize_q <= osize;
            vd_q    <= vd;
            vs1_q   <= vs1;
            vs2_q   <= vs2;
        end
        if (state == READ_WAIT && vrf_rvalid) begin
            src_a_q <= vrf_rdata_a;
            src_b_q <= vrf_rdata_b;
        end
    end

    // Subtract as a + ~b + 1, carry restarts at each element boundary
    assign src_b_eff = (op_q == VSUB) ? ~src_b_q : src_b_q;
    assign elem_mask = (4'd1 << osize_q) - 4'd1;

    always_comb begin : addsub
        logic [`BYTE_WIDTH:0] byte_sum;
        logic                 carry;
        carry    = 1'b0;
        byte_sum = '0;
        for (int i = 0; i < `RISCV_V_NUM_BYTES; i++) begin
            if ((i[3:0] & elem_mask) == 4'd0) begin
                carry = (op_q == VSUB);
            end
            byte_sum = {1'b0, src_a_q[i*`BYTE_WIDTH +: `BYTE_WIDTH]}
                     + {1'b0, src_b_eff[i*`BYTE_WIDTH +: `BYTE_WIDTH]} + carry;
            addsub_result[i*`BYTE_WIDTH +: `BYTE_WIDTH] = byte_sum[`BYTE_WIDTH-1:0];
            carry = byte_sum[`BYTE_WIDTH];
        end
    end

    always_comb begin
        case (op_q)
            VAND:    vrf_wdata = src_a_q & src_b_q;
            VOR:     vrf_wdata = src_a_q | src_b_q;
            VXOR:    vrf_wdata = src_a_q ^ src_b_q;
            default: vrf_wdata = addsub_result;
        endcase
    end

    assign vrf_req     = (state == READ_REQ) || (state == WRITE_REQ);
    assign vrf_we      = (state == WRITE_REQ);
    assign vrf_raddr_a = vs1_q;
    assign vrf_raddr_b = vs2_q;
    assign vrf_waddr   = vd_q;
    assign vrf_wbe     = '1;
    assign done        = (state == FINISH);

endmodule

//--- design/riscv_v_perm_unit.sv
// vmv.s.x and vmv.x.s only, always on element 0
// scalar_result holds its value until the next vmv.x.s
// A start while busy is ignored
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_perm_unit
    import riscv_v_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  riscv_v_opcode_e                 opcode,
    input  riscv_v_osize_e                  osize,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  vd,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  vs2,
    input  logic [`RISCV_DATA_WIDTH-1:0]    scalar_data,
    input  logic                            vrf_gnt,
    input  logic                            vrf_rvalid,
    input  logic [`RISCV_V_DATA_WIDTH-1:0]  vrf_rdata_b,
    output logic                            vrf_req,
    output logic                            vrf_we,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]  vrf_raddr_b,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]  vrf_waddr,
    output logic [`RISCV_V_DATA_WIDTH-1:0]  vrf_wdata,
    output logic [`RISCV_V_NUM_BYTES-1:0]   vrf_wbe,
    output logic                            done,
    output logic [`RISCV_DATA_WIDTH-1:0]    scalar_result
);

    riscv_v_unit_state_e            state;
    riscv_v_opcode_e                op_q;
    riscv_v_osize_e                 osize_q;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vd_q;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vs2_q;
    logic [`RISCV_DATA_WIDTH-1:0]   scalar_q;
    logic [`RISCV_V_DATA_WIDTH-1:0] scalar_ext;
    logic [3:0]                     osize_vector;
    logic [`RISCV_DATA_WIDTH-1:0]   alu_int_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= (opcode == VMV_S_X) ? WRITE_REQ : READ_REQ;
                    end
                end
                READ_REQ:  if (vrf_gnt) state <= READ_WAIT;
                READ_WAIT: if (vrf_rvalid) state <= FINISH;
                WRITE_REQ: if (vrf_gnt) state <= FINISH;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            op_q     <= opcode;
            osize_q  <= osize;
            vd_q     <= vd;
            vs2_q    <= vs2;
            scalar_q <= scalar_data;
        end
        if (state == READ_WAIT && vrf_rvalid) begin
            scalar_result <= alu_int_out;
        end
    end

    // Width one-hot and low-byte enables for element 0
    assign osize_vector = 4'b0001 << osize_q;

    always_comb begin
        for (int i = 0; i < `RISCV_V_NUM_BYTES; i++) begin
            vrf_wbe[i] = (i < (1 << osize_q));
        end
    end

    assign scalar_ext = {{(`RISCV_V_DATA_WIDTH - `RISCV_DATA_WIDTH){scalar_q[`RISCV_DATA_WIDTH-1]}},
                         scalar_q};

    riscv_v_permutation_alu perm_alu_i (
        .is_i2v           (op_q == VMV_S_X),
        .is_v2i           (op_q == VMV_X_S),
        .srca_data        (scalar_ext),
        .srcb_data        (vrf_rdata_b),
        .osize_vector     (osize_vector),
        .integer_data_out (alu_int_out),
        .vector_data_out  (vrf_wdata)
    );

    assign vrf_req     = (state == READ_REQ) || (state == WRITE_REQ);
    assign vrf_we      = (state == WRITE_REQ);
    assign vrf_raddr_b = vs2_q;
    assign vrf_waddr   = vd_q;
    assign done        = (state == FINISH);

endmodule

//--- design/riscv_v_vrf.sv
// Read data appears one cycle after the address
// A read of the register being written returns the old contents
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_vrf (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            we,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  waddr,
    input  logic [`RISCV_V_DATA_WIDTH-1:0]  wdata,
    input  logic [`RISCV_V_NUM_BYTES-1:0]   wbe,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  raddr_a,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  raddr_b,
    output logic [`RISCV_V_DATA_WIDTH-1:0]  rdata_a,
    output logic [`RISCV_V_DATA_WIDTH-1:0]  rdata_b
);

    logic [`RISCV_V_DATA_WIDTH-1:0] regs [`RISCV_V_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
            rdata_a <= '0;
            rdata_b <= '0;
        end else begin
            // Byte-masked write
            if (we) begin
                for (int i = 0; i < `RISCV_V_NUM_BYTES; i++) begin
                    if (wbe[i]) begin
                        regs[waddr][i*`BYTE_WIDTH +: `BYTE_WIDTH] <=
                            wdata[i*`BYTE_WIDTH +: `BYTE_WIDTH];
                    end
                end
            end
            rdata_a <= regs[raddr_a];
            rdata_b <= regs[raddr_b];
        end
    end

endmodule

//--- design/riscv_v_vrf_arbiter.sv
// Grant is combinational in the request cycle, one client at a time
// Search starts at the client after the last winner
// rvalid marks the cycle after a granted read
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_vrf_arbiter #(
    parameter int NUM_CLIENTS = 3
) (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic [NUM_CLIENTS-1:0]                          req,
    input  logic [NUM_CLIENTS-1:0]                          we,
    input  logic [NUM_CLIENTS-1:0][`RISCV_V_ADDR_WIDTH-1:0] raddr_a,
    input  logic [NUM_CLIENTS-1:0][`RISCV_V_ADDR_WIDTH-1:0] raddr_b,
    input  logic [NUM_CLIENTS-1:0][`RISCV_V_ADDR_WIDTH-1:0] waddr,
    input  logic [NUM_CLIENTS-1:0][`RISCV_V_DATA_WIDTH-1:0] wdata,
    input  logic [NUM_CLIENTS-1:0][`RISCV_V_NUM_BYTES-1:0]  wbe,
    output logic [NUM_CLIENTS-1:0]                          gnt,
    output logic [NUM_CLIENTS-1:0]                          rvalid,
    output logic                                            vrf_we,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]                  vrf_waddr,
    output logic [`RISCV_V_DATA_WIDTH-1:0]                  vrf_wdata,
    output logic [`RISCV_V_NUM_BYTES-1:0]                   vrf_wbe,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]                  vrf_raddr_a,
    output logic [`RISCV_V_ADDR_WIDTH-1:0]                  vrf_raddr_b
);

    localparam int IW = $clog2(NUM_CLIENTS);

    logic [IW-1:0] ptr;
    logic [IW-1:0] win;
    logic          any_gnt;

    always_comb begin : grant
        int   idx;
        logic found;
        gnt   = '0;
        win   = ptr;
        found = 1'b0;
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            idx = (int'(ptr) + k) % NUM_CLIENTS;
            if (!found && req[idx]) begin
                gnt[idx] = 1'b1;
                win      = IW'(idx);
                found    = 1'b1;
            end
        end
    end

    assign any_gnt = |gnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr    <= '0;
            rvalid <= '0;
        end else begin
            if (any_gnt) begin
                ptr <= (win == IW'(NUM_CLIENTS - 1)) ? '0 : win + 1'b1;
            end
            // Read winner, seen again when the data comes back
            rvalid <= gnt & ~we;
        end
    end

    assign vrf_we      = any_gnt & we[win];
    assign vrf_waddr   = waddr[win];
    assign vrf_wdata   = wdata[win];
    assign vrf_wbe     = wbe[win];
    assign vrf_raddr_a = raddr_a[win];
    assign vrf_raddr_b = raddr_b[win];

endmodule

//--- design/riscv_v_exec_top.sv
// Host, arith and perm share the VRF as arbiter clients 0, 1 and 2
// Each port takes a new command only after its done strobe
// Host reads return the whole register on host_rdata with host_done
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_exec_top
    import riscv_v_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            host_cmd,
    input  logic                            host_we,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  host_addr,
    input  logic [`RISCV_V_DATA_WIDTH-1:0]  host_wdata,
    input  logic                            arith_start,
    input  riscv_v_opcode_e                 arith_opcode,
    input  riscv_v_osize_e                  arith_osize,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  arith_vd,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  arith_vs1,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  arith_vs2,
    input  logic                            perm_start,
    input  riscv_v_opcode_e                 perm_opcode,
    input  riscv_v_osize_e                  perm_osize,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  perm_vd,
    input  logic [`RISCV_V_ADDR_WIDTH-1:0]  perm_vs2,
    input  logic [`RISCV_DATA_WIDTH-1:0]    perm_scalar,
    output logic                            host_done,
    output logic [`RISCV_V_DATA_WIDTH-1:0]  host_rdata,
    output logic                            arith_done,
    output logic                            perm_done,
    output logic [`RISCV_DATA_WIDTH-1:0]    perm_scalar_result
);

    // Host request holder
    logic                           host_pending;
    logic                           host_we_q;
    logic [`RISCV_V_ADDR_WIDTH-1:0] host_addr_q;
    logic [`RISCV_V_DATA_WIDTH-1:0] host_wdata_q;

    logic [2:0] gnt;
    logic [2:0] rvalid;

    logic                           arith_req;
    logic                           arith_we;
    logic [`RISCV_V_ADDR_WIDTH-1:0] arith_raddr_a;
    logic [`RISCV_V_ADDR_WIDTH-1:0] arith_raddr_b;
    logic [`RISCV_V_ADDR_WIDTH-1:0] arith_waddr;
    logic [`RISCV_V_DATA_WIDTH-1:0] arith_wdata;
    logic [`RISCV_V_NUM_BYTES-1:0]  arith_wbe;

    logic                           perm_req;
    logic                           perm_we;
    logic [`RISCV_V_ADDR_WIDTH-1:0] perm_raddr_b;
    logic [`RISCV_V_ADDR_WIDTH-1:0] perm_waddr;
    logic [`RISCV_V_DATA_WIDTH-1:0] perm_wdata;
    logic [`RISCV_V_NUM_BYTES-1:0]  perm_wbe;

    logic                           vrf_we;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vrf_waddr;
    logic [`RISCV_V_DATA_WIDTH-1:0] vrf_wdata;
    logic [`RISCV_V_NUM_BYTES-1:0]  vrf_wbe;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vrf_raddr_a;
    logic [`RISCV_V_ADDR_WIDTH-1:0] vrf_raddr_b;
    logic [`RISCV_V_DATA_WIDTH-1:0] vrf_rdata_a;
    logic [`RISCV_V_DATA_WIDTH-1:0] vrf_rdata_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            host_pending <= 1'b0;
        end else if (host_pending) begin
            host_pending <= !gnt[0];
        end else begin
            host_pending <= host_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (host_cmd && !host_pending) begin
            host_we_q    <= host_we;
            host_addr_q  <= host_addr;
            host_wdata_q <= host_wdata;
        end
    end

    // Write done on the commit cycle, read done when data returns
    assign host_done  = (gnt[0] & host_we_q) | rvalid[0];
    assign host_rdata = vrf_rdata_a;

    riscv_v_arith_unit arith_unit_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (arith_start),
        .opcode      (arith_opcode),
        .osize       (arith_osize),
        .vd          (arith_vd),
        .vs1         (arith_vs1),
        .vs2         (arith_vs2),
        .vrf_gnt     (gnt[1]),
        .vrf_rvalid  (rvalid[1]),
        .vrf_rdata_a (vrf_rdata_a),
        .vrf_rdata_b (vrf_rdata_b),
        .vrf_req     (arith_req),
        .vrf_we      (arith_we),
        .vrf_raddr_a (arith_raddr_a),
        .vrf_raddr_b (arith_raddr_b),
        .vrf_waddr   (arith_waddr),
        .vrf_wdata   (arith_wdata),
        .vrf_wbe     (arith_wbe),
        .done        (arith_done)
    );

    riscv_v_perm_unit perm_unit_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (perm_start),
        .opcode        (perm_opcode),
        .osize         (perm_osize),
        .vd            (perm_vd),
        .vs2           (perm_vs2),
        .scalar_data   (perm_scalar),
        .vrf_gnt       (gnt[2]),
        .vrf_rvalid    (rvalid[2]),
        .vrf_rdata_b   (vrf_rdata_b),
        .vrf_req       (perm_req),
        .vrf_we        (perm_we),
        .vrf_raddr_b   (perm_raddr_b),
        .vrf_waddr     (perm_waddr),
        .vrf_wdata     (perm_wdata),
        .vrf_wbe       (perm_wbe),
        .done          (perm_done),
        .scalar_result (perm_scalar_result)
    );

    // Perm unit reads only through port b
    riscv_v_vrf_arbiter vrf_arbiter_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         ({perm_req, arith_req, host_pending}),
        .we          ({perm_we, arith_we, host_we_q}),
        .raddr_a     ({perm_raddr_b, arith_raddr_a, host_addr_q}),
        .raddr_b     ({perm_raddr_b, arith_raddr_b, host_addr_q}),
        .waddr       ({perm_waddr, arith_waddr, host_addr_q}),
        .wdata       ({perm_wdata, arith_wdata, host_wdata_q}),
        .wbe         ({perm_wbe, arith_wbe, {`RISCV_V_NUM_BYTES{1'b1}}}),
        .gnt         (gnt),
        .rvalid      (rvalid),
        .vrf_we      (vrf_we),
        .vrf_waddr   (vrf_waddr),
        .vrf_wdata   (vrf_wdata),
        .vrf_wbe     (vrf_wbe),
        .vrf_raddr_a (vrf_raddr_a),
        .vrf_raddr_b (vrf_raddr_b)
    );

    riscv_v_vrf vrf_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (vrf_we),
        .waddr   (vrf_waddr),
        .wdata   (vrf_wdata),
        .wbe     (vrf_wbe),
        .raddr_a (vrf_raddr_a),
        .raddr_b (vrf_raddr_b),
        .rdata_a (vrf_rdata_a),
        .rdata_b (vrf_rdata_b)
    );

endmodule

//--- verif/riscv_v_exec_tb.sv
// Random host, arith and perm traffic checked against a VRF model kept in the testbench
// Stimulus repeats from the fixed LFSR seed
// Concurrent rounds use disjoint register ranges, so grant order cannot change results
`include "riscv_v_defines.svh"
`timescale 1ns/1ps

module riscv_v_exec_tb
    import riscv_v_pkg::*;
();

    localparam int N_ARITH = 20;
    localparam int N_SX    = 12;
    localparam int N_XS    = 12;
    localparam int N_CONC  = 8;
    // VRF operations over all tests
    localparam int NUM_OPS = 32 + 64 + 2 * N_ARITH + 2 * N_SX + N_XS + 3 * N_CONC + 32;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

    logic                           clk = 1'b0;
    logic                           arst_n;
    logic                           host_cmd;
    logic                           host_we;
    logic [`RISCV_V_ADDR_WIDTH-1:0] host_addr;
    logic [`RISCV_V_DATA_WIDTH-1:0] host_wdata;
    logic                           arith_start;
    riscv_v_opcode_e                arith_opcode;
    riscv_v_osize_e                 arith_osize;
    logic [`RISCV_V_ADDR_WIDTH-1:0] arith_vd;
    logic [`RISCV_V_ADDR_WIDTH-1:0] arith_vs1;
    logic [`RISCV_V_ADDR_WIDTH-1:0] arith_vs2;
    logic                           perm_start;
    riscv_v_opcode_e                perm_opcode;
    riscv_v_osize_e                 perm_osize;
    logic [`RISCV_V_ADDR_WIDTH-1:0] perm_vd;
    logic [`RISCV_V_ADDR_WIDTH-1:0] perm_vs2;
    logic [`RISCV_DATA_WIDTH-1:0]   perm_scalar;
    logic                           host_done;
    logic [`RISCV_V_DATA_WIDTH-1:0] host_rdata;
    logic                           arith_done;
    logic                           perm_done;
    logic [`RISCV_DATA_WIDTH-1:0]   perm_scalar_result;

    logic [`RISCV_V_DATA_WIDTH-1:0] model_vrf [`RISCV_V_NUM_REGS];
    logic [31:0]                    lfsr_state;
    int                             check_count;
    int                             error_count;
    int                             test_checks;
    int                             test_errors;
    int                             cycle_count;

    riscv_v_exec_top riscv_v_exec_top_i (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1
    // One step per returned bit
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        logic         fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[126:0], fb};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_bits(5));
    endfunction

    // Element-wise wraparound result at the given width
    function automatic logic [127:0] arith_model(input riscv_v_opcode_e op,
                                                 input riscv_v_osize_e osz,
                                                 input logic [127:0] a,
                                                 input logic [127:0] b);
        int           ew;
        logic [63:0]  mask;
        logic [63:0]  ea;
        logic [63:0]  eb;
        logic [63:0]  er;
        logic [127:0] res;
        ew   = 8 << osz;
        mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        res  = '0;
        for (int e = 0; e < 128 / ew; e++) begin
            ea = 64'(a >> (e * ew)) & mask;
            eb = 64'(b >> (e * ew)) & mask;
            case (op)
                VADD:    er = ea + eb;
                VSUB:    er = ea - eb;
                VAND:    er = ea & eb;
                VOR:     er = ea | eb;
                default: er = ea ^ eb;
            endcase
            res = res | (128'(er & mask) << (e * ew));
        end
        return res;
    endfunction

    function automatic logic [63:0] sign_extend(input logic [63:0] v, input riscv_v_osize_e osz);
        case (osz)
            OSIZE_8:  return {{56{v[7]}}, v[7:0]};
            OSIZE_16: return {{48{v[15]}}, v[15:0]};
            OSIZE_32: return {{32{v[31]}}, v[31:0]};
            default:  return v;
        endcase
    endfunction

    // Low 1, 2, 4 or 8 bytes take the scalar
    function automatic logic [127:0] insert_scalar(input logic [127:0] old,
                                                   input logic [63:0] s,
                                                   input riscv_v_osize_e osz);
        logic [127:0] mask;
        mask = (128'd1 << (8 << osz)) - 128'd1;
        return (old & ~mask) | ({64'd0, s} & mask);
    endfunction

    task automatic compare_value(input logic [127:0] actual, input logic [127:0] expected,
                                 input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        $display("%-20s checks %0d  errors %0d", name, check_count - test_checks,
                 error_count - test_errors);
    endtask

    task automatic host_write(input logic [4:0] addr, input logic [127:0] data);
        @(negedge clk);
        host_cmd   = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_cmd = 1'b0;
        while (!host_done) @(negedge clk);
        model_vrf[addr] = data;
    endtask

    task automatic check_readback(input logic [4:0] addr);
        @(negedge clk);
        host_cmd  = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        @(negedge clk);
        host_cmd = 1'b0;
        while (!host_done) @(negedge clk);
        compare_value(host_rdata, model_vrf[addr], $sformatf("readback of v%0d", addr));
    endtask

    task automatic run_arith(input riscv_v_opcode_e op, input riscv_v_osize_e osz,
                             input logic [4:0] vd, input logic [4:0] vs1, input logic [4:0] vs2);
        logic [127:0] expected;
        expected = arith_model(op, osz, model_vrf[vs1], model_vrf[vs2]);
        @(negedge clk);
        arith_start  = 1'b1;
        arith_opcode = op;
        arith_osize  = osz;
        arith_vd     = vd;
        arith_vs1    = vs1;
        arith_vs2    = vs2;
        @(negedge clk);
        arith_start = 1'b0;
        while (!arith_done) @(negedge clk);
        model_vrf[vd] = expected;
    endtask

    task automatic run_perm(input riscv_v_opcode_e op, input riscv_v_osize_e osz,
                            input logic [4:0] vd, input logic [4:0] vs2, input logic [63:0] s);
        logic [63:0] expected_int;
        expected_int = sign_extend(model_vrf[vs2][63:0], osz);
        @(negedge clk);
        perm_start  = 1'b1;
        perm_opcode = op;
        perm_osize  = osz;
        perm_vd     = vd;
        perm_vs2    = vs2;
        perm_scalar = s;
        @(negedge clk);
        perm_start = 1'b0;
        while (!perm_done) @(negedge clk);
        if (op == VMV_S_X) begin
            model_vrf[vd] = insert_scalar(model_vrf[vd], s, osz);
        end else begin
            compare_value({64'd0, perm_scalar_result}, {64'd0, expected_int},
                          $sformatf("vmv.x.s from v%0d", vs2));
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a done strobe never arrived", cycle_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        riscv_v_opcode_e op;
        riscv_v_opcode_e pop;
        riscv_v_osize_e  osz;
        riscv_v_osize_e  posz;
        logic [4:0]      hreg;
        logic [4:0]      vd;
        logic [4:0]      vs1;
        logic [4:0]      vs2;
        logic [4:0]      pvd;
        logic [4:0]      pvs2;
        logic [63:0]     scalar;
        logic [127:0]    hdata;
        lfsr_state   = 32'hcf63;
        check_count  = 0;
        error_count  = 0;
        arst_n       = 1'b0;
        host_cmd     = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        arith_start  = 1'b0;
        arith_opcode = VADD;
        arith_osize  = OSIZE_8;
        arith_vd     = '0;
        arith_vs1    = '0;
        arith_vs2    = '0;
        perm_start   = 1'b0;
        perm_opcode  = VMV_S_X;
        perm_osize   = OSIZE_8;
        perm_vd      = '0;
        perm_vs2     = '0;
        perm_scalar  = '0;
        for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
            model_vrf[r] = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        start_test();
        for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
            host_write(5'(r), rand_bits(128));
        end
        for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
            check_readback(5'(r));
        end
        end_test("host_load_readback");

        start_test();
        for (int n = 0; n < N_ARITH; n++) begin
            op  = riscv_v_opcode_e'(3'(rand_bits(3) % 5));
            osz = riscv_v_osize_e'(2'(rand_bits(2)));
            vd  = rand_reg();
            vs1 = rand_reg();
            vs2 = rand_reg();
            run_arith(op, osz, vd, vs1, vs2);
            check_readback(vd);
        end
        end_test("arith_ops");

        start_test();
        for (int n = 0; n < N_SX; n++) begin
            osz    = riscv_v_osize_e'(2'(rand_bits(2)));
            vd     = rand_reg();
            scalar = 64'(rand_bits(64));
            run_perm(VMV_S_X, osz, vd, 5'd0, scalar);
            check_readback(vd);
        end
        end_test("vmv_s_x");

        start_test();
        for (int n = 0; n < N_XS; n++) begin
            osz = riscv_v_osize_e'(2'(rand_bits(2)));
            run_perm(VMV_X_S, osz, 5'd0, rand_reg(), 64'(rand_bits(64)));
        end
        end_test("vmv_x_s");

        // Host on v0-v7, arith on v8-v23, perm on v24-v31
        start_test();
        for (int n = 0; n < N_CONC; n++) begin
            hreg   = 5'(rand_bits(3));
            hdata  = rand_bits(128);
            op     = riscv_v_opcode_e'(3'(rand_bits(3) % 5));
            osz    = riscv_v_osize_e'(2'(rand_bits(2)));
            vs1    = 5'd8 + 5'(rand_bits(3));
            vs2    = 5'd8 + 5'(rand_bits(3));
            vd     = 5'd16 + 5'(rand_bits(3));
            pop    = (rand_bits(1) != '0) ? VMV_S_X : VMV_X_S;
            posz   = riscv_v_osize_e'(2'(rand_bits(2)));
            pvd    = 5'd24 + 5'(rand_bits(2));
            pvs2   = 5'd28 + 5'(rand_bits(2));
            scalar = 64'(rand_bits(64));
            fork
                host_write(hreg, hdata);
                run_arith(op, osz, vd, vs1, vs2);
                run_perm(pop, posz, pvd, pvs2, scalar);
            join
        end
        for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
            check_readback(5'(r));
        end
        end_test("concurrent_traffic");

        // Reset again while every register holds nonzero data
        start_test();
        @(negedge clk);
        arst_n = 1'b0;
        for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
            model_vrf[r] = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        compare_value({125'd0, host_done, arith_done, perm_done}, '0, "done strobe after reset");
        for (int r = 0; r < `RISCV_V_NUM_REGS; r++) begin
            check_readback(5'(r));
        end
        end_test("reset_state");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/riscv_v_pkg.sv
design/riscv_v_permutation_alu.sv
design/riscv_v_arith_unit.sv
design/riscv_v_perm_unit.sv
design/riscv_v_vrf.sv
design/riscv_v_vrf_arbiter.sv
design/riscv_v_exec_top.sv
verif/riscv_v_exec_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; status is nonzero unless the run passes
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module riscv_v_exec_tb -f compile.f -o sim_tb \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Test completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
